/* breakStimulus.txt */
// Columns: cmd f1 f2 f3 f4 f5. cmd 0 idle, 1 write addr data, 2 read addr expected,
// 3 fetch iAddr break trace, 4 access store dAddr dData break trace, 5 debugReq expected
2 00 00000000 0 0 0
2 05 00000000 0 0 0
2 12 00000000 0 0 0
2 17 00000000 0 0 0
2 3f 00000000 0 0 0
1 04 00001000 0 0 0
1 05 0000000c 0 0 0
1 06 00000001 0 0 0
1 08 00002000 0 0 0
1 0a 00000003 0 0 0
1 10 00004000 0 0 0
1 13 00000005 0 0 0
1 14 00005000 0 0 0
1 16 cafef00d 0 0 0
1 17 00000019 0 0 0
2 05 0000000c 0 0 0
2 0a 00000003 0 0 0
2 16 cafef00d 0 0 0
2 17 00000019 0 0 0
// Trace channel, then break channel with exact, masked and missing addresses
3 00002000 0 1 0 0
0 0 0 0 0 0
5 0 0 0 0 0
2 00 00000002 0 0 0
3 00001000 1 0 0 0
3 00001008 1 0 0 0
3 00001010 0 0 0 0
0 0 0 0 0 0
5 1 0 0 0 0
1 00 00000003 0 0 0
5 0 0 0 0 0
2 00 00000000 0 0 0
1 06 00000000 0 0 0
3 00001000 0 0 0 0
// Data channels: load only, store only with value compare
4 1 00004000 00000000 0 0
4 0 00004003 00000000 1 0
4 0 00005000 cafef00d 0 0
4 1 00005000 12345678 0 0
4 1 00005002 cafef00d 1 0
0 0 0 0 0 0
5 1 0 0 0 0
2 01 00000003 0 0 0
1 01 00000003 0 0 0
5 0 0 0 0 0
// Hit arrives in the same cycle as the clear
4 0 00004000 00000000 1 0
1 01 00000001 0 0 0
0 0 0 0 0 0
2 01 00000001 0 0 0

/* filelist.f */
ejtagPkg.sv
instBreakMatch.sv
dataBreakMatch.sv
breakStatus.sv
ejtagBreakUnit.sv
tb_ejtagBreakUnit.sv

/* tb_ejtagBreakUnit.sv */
`timescale 1ns/1ps

module tb_ejtagBreakUnit;

  localparam int ClkPeriod  = 8;
  localparam int RecWords   = 6;   // Command word plus five fields per stimulus line
  localparam int MaxRecords = 64;

  logic              SYSCLK;
  logic              rstN;
  logic              regWr;
  logic              regRd;
  ejtagPkg::regAddrT regAddr;
  ejtagPkg::wordT    regWrData;
  logic              iSample;
  ejtagPkg::wordT    iAddr;
  logic              dSample;
  logic              dStore;
  ejtagPkg::wordT    dAddr;
  ejtagPkg::wordT    dData;
  logic              breakHit;
  logic              traceHit;
  logic              debugReq;
  ejtagPkg::wordT    regRdData;

  logic [31:0] stim [RecWords*MaxRecords];
  int          numRecords;
  bit          loaded;
  int          errors;
  int          checks;

  logic           brkPipe [2];  // Expected pulses where index 1 is due in the current cycle
  logic           trcPipe [2];
  ejtagPkg::wordT rdExpect;

  ejtagBreakUnit u_ejtagBreakUnit (
    .SYSCLK    (SYSCLK),
    .rstN      (rstN),
    .regWr     (regWr),
    .regRd     (regRd),
    .regAddr   (regAddr),
    .regWrData (regWrData),
    .iSample   (iSample),
    .iAddr     (iAddr),
    .dSample   (dSample),
    .dStore    (dStore),
    .dAddr     (dAddr),
    .dData     (dData),
    .breakHit  (breakHit),
    .traceHit  (traceHit),
    .debugReq  (debugReq),
    .regRdData (regRdData)
  );

  initial begin
    SYSCLK = 1'b0;
    forever #(ClkPeriod / 2) SYSCLK = ~SYSCLK;
  end

  task automatic checkWord(input string name, input ejtagPkg::wordT actual,
                           input ejtagPkg::wordT expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic driveIdle();
    regWr   = 1'b0;
    regRd   = 1'b0;
    iSample = 1'b0;
    dSample = 1'b0;
  endtask

  task automatic finishRun();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    int          base;
    logic [31:0] cmd;
    logic        curBrk;
    logic        curTrc;
    rstN      = 1'b0;
    driveIdle();
    regAddr   = '0;
    regWrData = '0;
    iAddr     = '0;
    dStore    = 1'b0;
    dAddr     = '0;
    dData     = '0;
    errors    = 0;
    checks    = 0;
    $readmemh("breakStimulus.txt", stim);
    numRecords = 0;
    while (numRecords < MaxRecords && !$isunknown(stim[numRecords*RecWords])) begin
      numRecords++;
    end
    loaded = 1'b1;
    if (numRecords == 0) begin
      errors++;
      $display("The stimulus file gave no records to run");
    end
    repeat (3) @(posedge SYSCLK);
    #1 rstN = 1'b1;
    @(negedge SYSCLK);
    checkWord("breakHit", breakHit, 0);
    checkWord("traceHit", traceHit, 0);
    checkWord("debugReq", debugReq, 0);
    checkWord("regRdData", regRdData, 0);
    brkPipe   = '{1'b0, 1'b0};
    trcPipe   = '{1'b0, 1'b0};
    rdExpect  = '0;
    // Two extra idle cycles let the last pulses and read arrive
    for (int idx = 0; idx < numRecords + 2; idx++) begin
      @(posedge SYSCLK);
      #1;
      driveIdle();
      curBrk = 1'b0;
      curTrc = 1'b0;
      base   = idx * RecWords;
      cmd    = 32'd0;
      if (idx < numRecords) begin
        cmd = stim[base];
      end
      case (cmd)
        32'd0: begin
        end
        32'd1: begin
          regWr     = 1'b1;
          regAddr   = stim[base+1][5:0];
          regWrData = stim[base+2];
        end
        32'd2: begin
          regRd   = 1'b1;
          regAddr = stim[base+1][5:0];
        end
        32'd3: begin
          iSample = 1'b1;
          iAddr   = stim[base+1];
          curBrk  = stim[base+2][0];
          curTrc  = stim[base+3][0];
        end
        32'd4: begin
          dSample = 1'b1;
          dStore  = stim[base+1][0];
          dAddr   = stim[base+2];
          dData   = stim[base+3];
          curBrk  = stim[base+4][0];
          curTrc  = stim[base+5][0];
        end
        32'd5: begin
        end
        default: begin
          errors++;
          $display("Stimulus record %0d has an unknown command 0x%0h", idx, cmd);
        end
      endcase
      @(negedge SYSCLK);
      checkWord("breakHit", breakHit, brkPipe[1]);
      checkWord("traceHit", traceHit, trcPipe[1]);
      checkWord("regRdData", regRdData, rdExpect);  // Read data holds between reads
      if (cmd == 32'd5) begin
        checkWord("debugReq", debugReq, stim[base+1][0]);
      end
      brkPipe[1] = brkPipe[0];
      brkPipe[0] = curBrk;
      trcPipe[1] = trcPipe[0];
      trcPipe[0] = curTrc;
      if (cmd == 32'd2) begin
        rdExpect = stim[base+2];
      end
    end
    finishRun();
  end

  initial begin
    wait (loaded);
    #((numRecords * 10 + 100) * ClkPeriod);
    errors++;
    $display("Timeout: the run did not finish within %0d cycles", numRecords * 10 + 100);
    finishRun();
  end

endmodule

/* ejtagBreakUnit.sv */
`timescale 1ns/1ps

module ejtagBreakUnit (
  input  logic              SYSCLK,
  input  logic              rstN,
  input  logic              regWr,
  input  logic              regRd,
  input  ejtagPkg::regAddrT regAddr,
  input  ejtagPkg::wordT    regWrData,
  input  logic              iSample,
  input  ejtagPkg::wordT    iAddr,
  input  logic              dSample,
  input  logic              dStore,
  input  ejtagPkg::wordT    dAddr,
  input  ejtagPkg::wordT    dData,
  output logic              breakHit,
  output logic              traceHit,
  output logic              debugReq,
  output ejtagPkg::wordT    regRdData
);

  ejtagPkg::instHitT instHit;
  ejtagPkg::instHitT instBreakMask;
  ejtagPkg::wordT    instRdData;
  ejtagPkg::dataHitT dataHit;
  ejtagPkg::dataHitT dataBreakMask;
  ejtagPkg::wordT    dataRdData;

  instBreakMatch u_instBreakMatch (
    .SYSCLK        (SYSCLK),
    .rstN          (rstN),
    .regWr         (regWr),
    .regAddr       (regAddr),
    .regWrData     (regWrData),
    .iSample       (iSample),
    .iAddr         (iAddr),
    .instHit       (instHit),
    .instBreakMask (instBreakMask),
    .instRdData    (instRdData)
  );

  dataBreakMatch u_dataBreakMatch (
    .SYSCLK        (SYSCLK),
    .rstN          (rstN),
    .regWr         (regWr),
    .regAddr       (regAddr),
    .regWrData     (regWrData),
    .dSample       (dSample),
    .dStore        (dStore),
    .dAddr         (dAddr),
    .dData         (dData),
    .dataHit       (dataHit),
    .dataBreakMask (dataBreakMask),
    .dataRdData    (dataRdData)
  );

  breakStatus u_breakStatus (
    .SYSCLK        (SYSCLK),
    .rstN          (rstN),
    .regWr         (regWr),
    .regRd         (regRd),
    .regAddr       (regAddr),
    .regWrData     (regWrData),
    .instHit       (instHit),
    .instBreakMask (instBreakMask),
    .dataHit       (dataHit),
    .dataBreakMask (dataBreakMask),
    .instRdData    (instRdData),
    .dataRdData    (dataRdData),
    .breakHit      (breakHit),
    .traceHit      (traceHit),
    .debugReq      (debugReq),
    .regRdData     (regRdData)
  );

endmodule

/* breakStatus.sv */
`timescale 1ns/1ps

module breakStatus (
  input  logic              SYSCLK,
  input  logic              rstN,
  input  logic              regWr,
  input  logic              regRd,
  input  ejtagPkg::regAddrT regAddr,
  input  ejtagPkg::wordT    regWrData,
  input  ejtagPkg::instHitT instHit,
  input  ejtagPkg::instHitT instBreakMask,
  input  ejtagPkg::dataHitT dataHit,
  input  ejtagPkg::dataHitT dataBreakMask,
  input  ejtagPkg::wordT    instRdData,
  input  ejtagPkg::wordT    dataRdData,
  output logic              breakHit,
  output logic              traceHit,
  output logic              debugReq,
  output ejtagPkg::wordT    regRdData
);

  ejtagPkg::instHitT ibsReg;
  ejtagPkg::dataHitT dbsReg;
  ejtagPkg::instHitT ibsClear;
  ejtagPkg::dataHitT dbsClear;
  ejtagPkg::wordT    statusRdData;

  // Write-one-to-clear masks for the two status registers
  assign ibsClear = (regWr && regAddr == ejtagPkg::RegIbs) ?
                    regWrData[ejtagPkg::NumInstBreaks-1:0] : '0;
  assign dbsClear = (regWr && regAddr == ejtagPkg::RegDbs) ?
                    regWrData[ejtagPkg::NumDataBreaks-1:0] : '0;

  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      ibsReg   <= '0;
      dbsReg   <= '0;
      breakHit <= 1'b0;
      traceHit <= 1'b0;
    end else begin
      ibsReg   <= (ibsReg & ~ibsClear) | instHit;  // A hit in the clear cycle survives
      dbsReg   <= (dbsReg & ~dbsClear) | dataHit;
      breakHit <= |(instHit & instBreakMask) || |(dataHit & dataBreakMask);
      traceHit <= |(instHit & ~instBreakMask) || |(dataHit & ~dataBreakMask);
    end
  end

  assign debugReq = |(ibsReg & instBreakMask) || |(dbsReg & dataBreakMask);

  always_comb begin
    statusRdData = '0;
    if (regAddr == ejtagPkg::RegIbs) begin
      statusRdData = ejtagPkg::wordT'(ibsReg);
    end
    if (regAddr == ejtagPkg::RegDbs) begin
      statusRdData = ejtagPkg::wordT'(dbsReg);
    end
  end

  // Read data holds until the next read strobe
  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      regRdData <= '0;
    end else if (regRd) begin
      regRdData <= statusRdData | instRdData | dataRdData;
    end
  end

endmodule

/* dataBreakMatch.sv */
`timescale 1ns/1ps

module dataBreakMatch (
  input  logic              SYSCLK,
  input  logic              rstN,
  input  logic              regWr,
  input  ejtagPkg::regAddrT regAddr,
  input  ejtagPkg::wordT    regWrData,
  input  logic              dSample,
  input  logic              dStore,
  input  ejtagPkg::wordT    dAddr,
  input  ejtagPkg::wordT    dData,
  output ejtagPkg::dataHitT dataHit,
  output ejtagPkg::dataHitT dataBreakMask,
  output ejtagPkg::wordT    dataRdData
);

  ejtagPkg::wordT addrReg  [ejtagPkg::NumDataBreaks];
  ejtagPkg::wordT maskReg  [ejtagPkg::NumDataBreaks];
  ejtagPkg::wordT valueReg [ejtagPkg::NumDataBreaks];
  logic [ejtagPkg::CtlValue:0] ctlReg [ejtagPkg::NumDataBreaks];

  ejtagPkg::wordT    addrDiff [ejtagPkg::NumDataBreaks];
  ejtagPkg::dataHitT addrOk;
  ejtagPkg::dataHitT typeOk;
  ejtagPkg::dataHitT valueOk;
  ejtagPkg::dataHitT matchNow;

  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      for (int n = 0; n < ejtagPkg::NumDataBreaks; n++) begin
        addrReg[n]  <= '0;
        maskReg[n]  <= '0;
        valueReg[n] <= '0;
        ctlReg[n]   <= '0;
      end
    end else if (regWr) begin
      for (int n = 0; n < ejtagPkg::NumDataBreaks; n++) begin
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataAddrOff)) begin
          addrReg[n] <= regWrData;
        end
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataMaskOff)) begin
          maskReg[n] <= regWrData;
        end
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataValueOff)) begin
          valueReg[n] <= regWrData;
        end
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataCtlOff)) begin
          ctlReg[n] <= regWrData[ejtagPkg::CtlValue:0];
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < ejtagPkg::NumDataBreaks; n++) begin
      addrDiff[n] = (dAddr ^ addrReg[n]) & ~maskReg[n];
      addrOk[n]   = (addrDiff[n][31:2] == '0);  // Byte lane bits never take part
      typeOk[n]   = dStore ? ctlReg[n][ejtagPkg::CtlStore] : ctlReg[n][ejtagPkg::CtlLoad];
      valueOk[n]  = !ctlReg[n][ejtagPkg::CtlValue] || (dData == valueReg[n]);
      matchNow[n] = ctlReg[n][ejtagPkg::CtlEnable] && addrOk[n] && typeOk[n] && valueOk[n];
      dataBreakMask[n] = ~ctlReg[n][ejtagPkg::CtlTrace];
    end
  end

  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      dataHit <= '0;
    end else begin
      dataHit <= dSample ? matchNow : '0;
    end
  end

  always_comb begin
    dataRdData = '0;
    for (int n = 0; n < ejtagPkg::NumDataBreaks; n++) begin
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataAddrOff)) begin
        dataRdData = addrReg[n];
      end
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataMaskOff)) begin
        dataRdData = maskReg[n];
      end
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataValueOff)) begin
        dataRdData = valueReg[n];
      end
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::DataBase, n, ejtagPkg::DataCtlOff)) begin
        dataRdData = ejtagPkg::wordT'(ctlReg[n]);
      end
    end
  end

endmodule

/* instBreakMatch.sv */
`timescale 1ns/1ps

module instBreakMatch (
  input  logic              SYSCLK,
  input  logic              rstN,
  input  logic              regWr,
  input  ejtagPkg::regAddrT regAddr,
  input  ejtagPkg::wordT    regWrData,
  input  logic              iSample,
  input  ejtagPkg::wordT    iAddr,
  output ejtagPkg::instHitT instHit,
  output ejtagPkg::instHitT instBreakMask,
  output ejtagPkg::wordT    instRdData
);

  ejtagPkg::wordT addrReg [ejtagPkg::NumInstBreaks];
  ejtagPkg::wordT maskReg [ejtagPkg::NumInstBreaks];  // A set bit ignores that address bit
  logic [ejtagPkg::CtlTrace:0] ctlReg [ejtagPkg::NumInstBreaks];

  ejtagPkg::wordT    addrDiff [ejtagPkg::NumInstBreaks];
  ejtagPkg::instHitT matchNow;

  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      for (int n = 0; n < ejtagPkg::NumInstBreaks; n++) begin
        addrReg[n] <= '0;
        maskReg[n] <= '0;
        ctlReg[n]  <= '0;
      end
    end else if (regWr) begin
      for (int n = 0; n < ejtagPkg::NumInstBreaks; n++) begin
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::InstBase, n, ejtagPkg::InstAddrOff)) begin
          addrReg[n] <= regWrData;
        end
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::InstBase, n, ejtagPkg::InstMaskOff)) begin
          maskReg[n] <= regWrData;
        end
        if (regAddr == ejtagPkg::chanReg(ejtagPkg::InstBase, n, ejtagPkg::InstCtlOff)) begin
          ctlReg[n] <= regWrData[ejtagPkg::CtlTrace:0];
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < ejtagPkg::NumInstBreaks; n++) begin
      addrDiff[n]      = (iAddr ^ addrReg[n]) & ~maskReg[n];
      matchNow[n]      = ctlReg[n][ejtagPkg::CtlEnable] && (addrDiff[n] == '0);
      instBreakMask[n] = ~ctlReg[n][ejtagPkg::CtlTrace];
    end
  end

  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      instHit <= '0;
    end else begin
      instHit <= iSample ? matchNow : '0;  // Only a sample cycle can produce a hit
    end
  end

  always_comb begin
    instRdData = '0;
    for (int n = 0; n < ejtagPkg::NumInstBreaks; n++) begin
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::InstBase, n, ejtagPkg::InstAddrOff)) begin
        instRdData = addrReg[n];
      end
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::InstBase, n, ejtagPkg::InstMaskOff)) begin
        instRdData = maskReg[n];
      end
      if (regAddr == ejtagPkg::chanReg(ejtagPkg::InstBase, n, ejtagPkg::InstCtlOff)) begin
        instRdData = ejtagPkg::wordT'(ctlReg[n]);
      end
    end
  end

endmodule

/* ejtagPkg.sv */
package ejtagPkg;

  typedef logic [31:0] wordT;     // Bus word for addresses, data and register contents
  typedef logic [5:0]  regAddrT;  // Register word index taken from address bits 7:2

  localparam int NumInstBreaks = 2;
  localparam int NumDataBreaks = 2;

  typedef logic [NumInstBreaks-1:0] instHitT;
  typedef logic [NumDataBreaks-1:0] dataHitT;

  // Status registers
  localparam regAddrT RegIbs = 6'd0;
  localparam regAddrT RegDbs = 6'd1;

  // Each channel owns a block of four register slots
  localparam int ChanStride = 4;

  localparam regAddrT InstBase = 6'd4;
  localparam int InstAddrOff = 0;
  localparam int InstMaskOff = 1;
  localparam int InstCtlOff  = 2;

  localparam regAddrT DataBase = 6'd16;
  localparam int DataAddrOff  = 0;
  localparam int DataMaskOff  = 1;
  localparam int DataValueOff = 2;
  localparam int DataCtlOff   = 3;

  // Control register bits
  localparam int CtlEnable = 0;
  localparam int CtlTrace  = 1;  // Set for a trace hit, clear for a break hit
  localparam int CtlLoad   = 2;
  localparam int CtlStore  = 3;
  localparam int CtlValue  = 4;

  function automatic regAddrT chanReg(input regAddrT base, input int chan, input int offset);
    int index;
    index = int'(base) + ChanStride * chan + offset;
    return regAddrT'(index);
  endfunction

endpackage
